// ==== Bender.yml ====
package:
  name: stack_cpu

sources:
  - include_dirs:
      - design
    files:
      - design/stack_cpu_pkg.sv
      - design/insn_decode.sv
      - design/alu_execute.sv
      - design/operand_stack.sv
      - design/mem_result.sv
      - design/stack_cpu.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/stack_cpu_assert.sv
      - tb/stack_cpu_tb.sv

// ==== design/alu_execute.sv ====
`timescale 1ns/10ps

module alu_execute (
  input  stack_cpu_pkg::word_t a,
  input  stack_cpu_pkg::word_t b,
  input  stack_cpu_pkg::word_t imm_field,
  input  stack_cpu_pkg::ctrl_t ctrl,
  output stack_cpu_pkg::word_t alu_out
);

  stack_cpu_pkg::word_t imm;  // masked, extended immediate
  stack_cpu_pkg::word_t opb;  // operand b after source select

  always_comb begin
    case (ctrl.imm_width)
      2'd0:    imm = imm_field;
      2'd1:    imm = {{2{ctrl.imm_sign & imm_field[13]}}, imm_field[13:0]};
      2'd2:    imm = {{4{ctrl.imm_sign & imm_field[11]}}, imm_field[11:0]};
      default: imm = {4'd0, imm_field[11:1], 1'b0};  // bit 0 is the LD/ST flag
    endcase
  end

  assign opb = (ctrl.src_b == stack_cpu_pkg::src_b_imm) ? imm : b;

  // binary stack ops compute stack[1] op stack[0], i.e. b op a
  always_comb begin
    case (ctrl.alu_op)
      stack_cpu_pkg::alu_a:   alu_out = a;
      stack_cpu_pkg::alu_b:   alu_out = opb;
      stack_cpu_pkg::alu_inc: alu_out = a + 1'b1;
      stack_cpu_pkg::alu_not: alu_out = ~a;
      stack_cpu_pkg::alu_and: alu_out = opb & a;
      stack_cpu_pkg::alu_or:  alu_out = opb | a;
      stack_cpu_pkg::alu_xor: alu_out = opb ^ a;
      stack_cpu_pkg::alu_shr: alu_out = opb >> a;
      stack_cpu_pkg::alu_sar: alu_out = $signed(opb) >>> a;
      stack_cpu_pkg::alu_shl: alu_out = opb << a;
      stack_cpu_pkg::alu_add: alu_out = a + opb;    // also X+imm and branch targets
      stack_cpu_pkg::alu_sub: alu_out = opb - a;
      stack_cpu_pkg::alu_eq:  alu_out = stack_cpu_pkg::word_t'(opb == a);
      stack_cpu_pkg::alu_neq: alu_out = stack_cpu_pkg::word_t'(opb != a);
      stack_cpu_pkg::alu_lt:  alu_out = stack_cpu_pkg::word_t'($signed(opb) < $signed(a));
      stack_cpu_pkg::alu_bt:  alu_out = stack_cpu_pkg::word_t'(opb < a);
      default:                alu_out = a;  // unsupported codes behave like NOP
    endcase
  end

endmodule

// ==== design/insn_decode.sv ====
`timescale 1ns/10ps

module insn_decode (
  input  logic                  clk,
  input  logic                  rst,
  input  stack_cpu_pkg::insn_t  insn,
  input  logic                  stk0_zero,
  output stack_cpu_pkg::phase_e phase,
  output stack_cpu_pkg::ctrl_t  ctrl
);

  stack_cpu_pkg::src_a_e x_base;   // X of the X+uimm12 forms
  logic                  is_load;  // LD or LD1

  // X select in insn[13:12]
  always_comb begin
    case (insn[13:12])
      2'd1:    x_base = stack_cpu_pkg::src_a_fp;
      2'd2:    x_base = stack_cpu_pkg::src_a_dp;
      default: x_base = stack_cpu_pkg::src_a_zero;  // 0, and 3 is reserved
    endcase
  end

  assign is_load = (insn[17:14] == 4'b0010) || (insn[17:14] == 4'b0100 && !insn[0]);

  // fetch -> exec -> (load_wait) -> fetch
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      phase <= stack_cpu_pkg::ph_fetch;
    end else begin
      case (phase)
        stack_cpu_pkg::ph_fetch: phase <= stack_cpu_pkg::ph_exec;
        stack_cpu_pkg::ph_exec:  phase <= is_load ? stack_cpu_pkg::ph_load_wait
                                                  : stack_cpu_pkg::ph_fetch;
        default:                 phase <= stack_cpu_pkg::ph_fetch;
      endcase
    end
  end

  always_comb begin
    ctrl = '0;  // pass a from stack[0], nothing enabled
    case (phase)
      stack_cpu_pkg::ph_fetch: begin
        ctrl.src_a   = stack_cpu_pkg::src_a_ip;  // ip++
        ctrl.alu_op  = stack_cpu_pkg::alu_inc;
        ctrl.load_ip = 1'b1;
      end
      stack_cpu_pkg::ph_load_wait: begin
        ctrl.push = 1'b1;  // read data arrives now
      end
      default: begin
        if (insn[17:16] == 2'b11) begin  // PUSH uimm16
          ctrl.src_a  = stack_cpu_pkg::src_a_zero;
          ctrl.src_b  = stack_cpu_pkg::src_b_imm;
          ctrl.alu_op = stack_cpu_pkg::alu_add;
          ctrl.push   = 1'b1;
        end else begin
          casez (insn[17:12])
            6'b0000??: begin  // CALL simm14, return address is ip
              ctrl.src_a     = stack_cpu_pkg::src_a_ip;
              ctrl.src_b     = stack_cpu_pkg::src_b_imm;
              ctrl.alu_op    = stack_cpu_pkg::alu_add;
              ctrl.imm_sign  = 1'b1;
              ctrl.imm_width = 2'd1;
              ctrl.load_ip   = 1'b1;
              ctrl.cpush     = 1'b1;
            end
            6'b000100, 6'b000110: begin  // JMP, JZ (bit 13 set)
              ctrl.src_a     = stack_cpu_pkg::src_a_ip;
              ctrl.src_b     = stack_cpu_pkg::src_b_imm;
              ctrl.alu_op    = stack_cpu_pkg::alu_add;
              ctrl.imm_sign  = 1'b1;
              ctrl.imm_width = 2'd2;
              ctrl.load_ip   = insn[13] ? stk0_zero : 1'b1;
              ctrl.pop       = insn[13];  // JZ drops the tested value
            end
            6'b000101: begin  // ADD fp,simm12
              ctrl.src_a     = stack_cpu_pkg::src_a_fp;
              ctrl.src_b     = stack_cpu_pkg::src_b_imm;
              ctrl.alu_op    = stack_cpu_pkg::alu_add;
              ctrl.imm_sign  = 1'b1;
              ctrl.imm_width = 2'd2;
              ctrl.load_fp   = 1'b1;
            end
            6'b001???: begin  // LD1 / ST1, bit 14 marks the store
              ctrl.src_a     = x_base;
              ctrl.src_b     = stack_cpu_pkg::src_b_imm;
              ctrl.alu_op    = stack_cpu_pkg::alu_add;
              ctrl.imm_width = 2'd2;
              ctrl.byt       = 1'b1;
              ctrl.dmem_ren  = !insn[14];
              ctrl.dmem_wen  = insn[14];
              ctrl.pop       = insn[14];  // store consumes stack[0]
            end
            6'b0100??: begin  // LD / ST, bit 0 marks the store
              ctrl.src_a     = x_base;
              ctrl.src_b     = stack_cpu_pkg::src_b_imm;
              ctrl.alu_op    = stack_cpu_pkg::alu_add;
              ctrl.imm_width = 2'd3;  // word aligned offset
              ctrl.dmem_ren  = !insn[0];
              ctrl.dmem_wen  = insn[0];
              ctrl.pop       = insn[0];
            end
            6'b0101??: begin  // PUSH X+uimm12
              ctrl.src_a     = x_base;
              ctrl.src_b     = stack_cpu_pkg::src_b_imm;
              ctrl.alu_op    = stack_cpu_pkg::alu_add;
              ctrl.imm_width = 2'd2;
              ctrl.push      = 1'b1;
            end
            6'b011100: begin
              if (!insn[11]) begin
                // stack-only ops: push/pop bits and alu field straight from insn
                ctrl.alu_op   = stack_cpu_pkg::alu_op_e'(insn[5:0]);
                ctrl.push     = insn[7];
                ctrl.pop      = insn[6];
                ctrl.load_stk = 1'b1;
              end else if (insn[3:0] == 4'd0) begin  // RET
                ctrl.src_a   = stack_cpu_pkg::src_a_cstk;
                ctrl.load_ip = 1'b1;
                ctrl.cpop    = 1'b1;
              end
            end
            default: ;  // reserved and binop forms run as NOP
          endcase
        end
      end
    endcase
  end

endmodule

// ==== design/mem_result.sv ====
`timescale 1ns/10ps

module mem_result (
  input  logic                 clk,
  input  logic                 rst,
  input  stack_cpu_pkg::ctrl_t ctrl,
  input  stack_cpu_pkg::addr_t addr,
  input  stack_cpu_pkg::word_t stk0,
  input  stack_cpu_pkg::word_t stk1,
  input  stack_cpu_pkg::word_t alu_out,
  input  stack_cpu_pkg::word_t dmem_rdata,
  output stack_cpu_pkg::word_t wdata,
  output stack_cpu_pkg::word_t stack_in
);

  stack_cpu_pkg::word_t st_word;  // store data before lane shift
  logic ren_d;                    // read issued last cycle
  logic byt_d;
  logic a0_d;                     // byte lane of that read

  assign st_word = ctrl.wr_stk1 ? stk1 : stk0;
  assign wdata   = (ctrl.byt && addr[0]) ? {st_word[7:0], 8'h00} : st_word;  // odd -> high lane

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ren_d <= 1'b0;
      byt_d <= 1'b0;
      a0_d  <= 1'b0;
    end else begin
      ren_d <= ctrl.dmem_ren;
      byt_d <= ctrl.byt;
      a0_d  <= addr[0];
    end
  end

  // loaded byte comes back zero extended
  always_comb begin
    if (!ren_d) stack_in = alu_out;
    else if (!byt_d) stack_in = dmem_rdata;
    else if (a0_d) stack_in = {8'h00, dmem_rdata[15:8]};
    else stack_in = {8'h00, dmem_rdata[7:0]};
  end

endmodule

// ==== design/operand_stack.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module operand_stack (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push,
  input  logic                 pop,
  input  logic                 load,
  input  stack_cpu_pkg::word_t data_in,
  output stack_cpu_pkg::word_t data0,
  output stack_cpu_pkg::word_t data1
);

  stack_cpu_pkg::word_t stk [`STACK_CPU_STACK_DEPTH];  // stk[0] is the top

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < `STACK_CPU_STACK_DEPTH; i++) begin
        stk[i] <= '0;
      end
    end else if (push) begin
      stk[0] <= data_in;
      for (int i = 1; i < `STACK_CPU_STACK_DEPTH; i++) begin
        stk[i] <= stk[i-1];  // shift down
      end
    end else if (pop) begin
      for (int i = 0; i < `STACK_CPU_STACK_DEPTH - 1; i++) begin
        stk[i] <= stk[i+1];  // shift up
      end
      stk[`STACK_CPU_STACK_DEPTH-1] <= '0;
      if (load) begin
        stk[0] <= data_in;  // binary op result replaces new top
      end
    end else if (load) begin
      stk[0] <= data_in;
    end
  end

  assign data0 = stk[0];
  assign data1 = stk[1];

endmodule

// ==== design/stack_cpu.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module stack_cpu (
  input  logic                     clk,
  input  logic                     rst,
  output stack_cpu_pkg::addr_t     pmem_addr,
  input  stack_cpu_pkg::insn_t     pmem_rdata,
  output stack_cpu_pkg::dmem_req_t dmem,
  input  stack_cpu_pkg::word_t     dmem_rdata
);

  stack_cpu_pkg::word_t  fp;        // frame pointer
  stack_cpu_pkg::word_t  dp;        // data pointer
  stack_cpu_pkg::word_t  ip;        // next instruction
  stack_cpu_pkg::insn_t  insn;
  stack_cpu_pkg::ctrl_t  ctrl;
  stack_cpu_pkg::phase_e phase;
  stack_cpu_pkg::word_t  src_a;
  stack_cpu_pkg::word_t  stk0;
  stack_cpu_pkg::word_t  stk1;
  stack_cpu_pkg::word_t  cstk0;     // top of call stack
  stack_cpu_pkg::word_t  stack_in;
  stack_cpu_pkg::word_t  alu_out;
  stack_cpu_pkg::word_t  wdata;
  logic                  stk0_zero;

  assign stk0_zero = (stk0 == '0);

  // operand a select
  always_comb begin
    case (ctrl.src_a)
      stack_cpu_pkg::src_a_fp:   src_a = fp;
      stack_cpu_pkg::src_a_dp:   src_a = dp;
      stack_cpu_pkg::src_a_ip:   src_a = ip;
      stack_cpu_pkg::src_a_cstk: src_a = cstk0;
      stack_cpu_pkg::src_a_zero: src_a = '0;
      default:                   src_a = stk0;
    endcase
  end

  // next fetch address goes out one cycle ahead, taken branch target in exec
  assign pmem_addr = (phase == stack_cpu_pkg::ph_exec && ctrl.load_ip)
                   ? alu_out[`STACK_CPU_ADDR_W-1:0] : ip[`STACK_CPU_ADDR_W-1:0];

  always_comb begin
    dmem.addr  = alu_out[`STACK_CPU_ADDR_W-1:0];  // X+imm
    dmem.wdata = wdata;
    dmem.ren   = ctrl.dmem_ren;
    dmem.wen   = ctrl.dmem_wen;
    dmem.byt   = ctrl.byt;
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fp <= `STACK_CPU_FP_INIT;
    end else if (ctrl.load_fp) begin
      fp <= alu_out;
    end
  end

  // nothing in this instruction set writes dp
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      dp <= `STACK_CPU_DP_INIT;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ip <= '0;
    end else if (ctrl.load_ip) begin
      ip <= alu_out;  // ip+1 in fetch, target in exec
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      insn <= '0;
    end else if (phase == stack_cpu_pkg::ph_fetch) begin
      insn <= pmem_rdata;  // held through exec and load_wait
    end
  end

  insn_decode u_decode (
    .clk       (clk),
    .rst       (rst),
    .insn      (insn),
    .stk0_zero (stk0_zero),
    .phase     (phase),
    .ctrl      (ctrl)
  );

  alu_execute u_alu (
    .a         (src_a),
    .b         (stk1),
    .imm_field (insn[`STACK_CPU_DATA_W-1:0]),
    .ctrl      (ctrl),
    .alu_out   (alu_out)
  );

  operand_stack u_dstack (
    .clk     (clk),
    .rst     (rst),
    .push    (ctrl.push),
    .pop     (ctrl.pop),
    .load    (ctrl.load_stk),
    .data_in (stack_in),
    .data0   (stk0),
    .data1   (stk1)
  );

  // return addresses, ip is already past the CALL in exec
  operand_stack u_cstack (
    .clk     (clk),
    .rst     (rst),
    .push    (ctrl.cpush),
    .pop     (ctrl.cpop),
    .load    (1'b0),
    .data_in (ip),
    .data0   (cstk0),
    .data1   ()
  );

  mem_result u_mem (
    .clk        (clk),
    .rst        (rst),
    .ctrl       (ctrl),
    .addr       (dmem.addr),
    .stk0       (stk0),
    .stk1       (stk1),
    .alu_out    (alu_out),
    .dmem_rdata (dmem_rdata),
    .wdata      (wdata),
    .stack_in   (stack_in)
  );

endmodule

// ==== design/stack_cpu_defs.svh ====
`ifndef STACK_CPU_DEFS_SVH
`define STACK_CPU_DEFS_SVH

// datapath widths
`define STACK_CPU_DATA_W 16   // data word
`define STACK_CPU_INSN_W 18   // instruction word
`define STACK_CPU_ADDR_W 14   // program and data memory address

// entries per stack, same for data and call stack
`define STACK_CPU_STACK_DEPTH 8

// register reset values
`define STACK_CPU_FP_INIT 16'h4000   // frames grow down toward 0
`define STACK_CPU_DP_INIT 16'h0100   // start of data ram

`endif

// ==== design/stack_cpu_pkg.sv ====
`include "stack_cpu_defs.svh"

package stack_cpu_pkg;

  typedef logic [`STACK_CPU_DATA_W-1:0] word_t;
  typedef logic [`STACK_CPU_INSN_W-1:0] insn_t;
  typedef logic [`STACK_CPU_ADDR_W-1:0] addr_t;

  // same codes as the alu field of the stack-only instructions
  typedef enum logic [5:0] {
    alu_a   = 6'h00,  // pass a
    alu_inc = 6'h01,
    alu_not = 6'h04,
    alu_b   = 6'h0f,  // pass b
    alu_and = 6'h10,
    alu_or  = 6'h11,
    alu_xor = 6'h12,
    alu_shr = 6'h14,
    alu_sar = 6'h15,
    alu_shl = 6'h16,
    alu_add = 6'h20,
    alu_sub = 6'h21,
    alu_eq  = 6'h28,
    alu_neq = 6'h29,
    alu_lt  = 6'h2a,  // signed
    alu_bt  = 6'h2c   // unsigned
  } alu_op_e;

  typedef enum logic [2:0] {
    src_a_stk0 = 3'd0,
    src_a_fp   = 3'd1,
    src_a_dp   = 3'd2,
    src_a_ip   = 3'd3,
    src_a_cstk = 3'd4,
    src_a_zero = 3'd5
  } src_a_e;

  typedef enum logic [1:0] {
    src_b_stk1 = 2'd0,
    src_b_imm  = 2'd1
  } src_b_e;

  typedef enum logic [1:0] {
    ph_fetch     = 2'd0,
    ph_exec      = 2'd1,
    ph_load_wait = 2'd2
  } phase_e;

  typedef struct packed {
    alu_op_e    alu_op;
    src_a_e     src_a;
    src_b_e     src_b;
    logic       imm_sign;   // sign extend the immediate
    logic [1:0] imm_width;  // 0 uimm16, 1 imm14, 2 imm12, 3 uimm11 with bit 0 cleared
    logic       push;       // data stack
    logic       pop;
    logic       load_stk;
    logic       cpush;      // call stack
    logic       cpop;
    logic       load_fp;
    logic       load_ip;
    logic       dmem_ren;
    logic       dmem_wen;
    logic       byt;
    logic       wr_stk1;    // store data from stack[1] instead of stack[0]
  } ctrl_t;

  typedef struct packed {
    addr_t addr;
    word_t wdata;
    logic  ren;
    logic  wen;
    logic  byt;
  } dmem_req_t;

endpackage

// ==== stack_cpu.f ====
+incdir+design
design/stack_cpu_pkg.sv
design/insn_decode.sv
design/alu_execute.sv
design/operand_stack.sv
design/mem_result.sv
design/stack_cpu.sv
tb/stack_cpu_assert.sv
tb/stack_cpu_tb.sv

// ==== tb/stack_cpu_assert.sv ====
`timescale 1ns/10ps

module stack_cpu_assert (
  input logic                     clk,
  input logic                     rst,
  input stack_cpu_pkg::addr_t     pmem_addr,
  input stack_cpu_pkg::phase_e    phase,
  input stack_cpu_pkg::dmem_req_t dmem
);

  int fail_cnt = 0;  // failed assertions so far

  // no strobes, fetch from 0 while held in reset
  a_reset_quiet: assert property (@(posedge clk)
    rst |-> !dmem.ren && !dmem.wen && pmem_addr == '0)
  else begin
    $error("memory strobes or fetch address active during reset");
    fail_cnt++;
  end

  // first cycle out of reset is a fetch from 0
  a_first_fetch: assert property (@(posedge clk)
    $fell(rst) |-> phase == stack_cpu_pkg::ph_fetch && pmem_addr == '0)
  else begin
    $error("first fetch after reset not at address 0");
    fail_cnt++;
  end

  a_fetch_exec: assert property (@(posedge clk) disable iff (rst)
    phase == stack_cpu_pkg::ph_fetch |=> phase == stack_cpu_pkg::ph_exec)
  else begin
    $error("fetch not followed by exec");
    fail_cnt++;
  end

  // plain instruction, next fetch two cycles after the last
  a_plain_two: assert property (@(posedge clk) disable iff (rst)
    phase == stack_cpu_pkg::ph_exec && !dmem.ren |=> phase == stack_cpu_pkg::ph_fetch)
  else begin
    $error("instruction without load did not return to fetch");
    fail_cnt++;
  end

  // load spends one extra cycle waiting on read data
  a_load_three: assert property (@(posedge clk) disable iff (rst)
    phase == stack_cpu_pkg::ph_exec && dmem.ren
      |=> phase == stack_cpu_pkg::ph_load_wait ##1 phase == stack_cpu_pkg::ph_fetch)
  else begin
    $error("load did not take exactly three cycles");
    fail_cnt++;
  end

  a_no_rw: assert property (@(posedge clk) disable iff (rst) !(dmem.ren && dmem.wen))
  else begin
    $error("data memory read and write strobes high together");
    fail_cnt++;
  end

endmodule

bind stack_cpu stack_cpu_assert u_chk (
  .clk       (clk),
  .rst       (rst),
  .pmem_addr (pmem_addr),
  .phase     (phase),
  .dmem      (dmem)
);

// ==== tb/stack_cpu_tb.sv ====
`timescale 1ns/10ps
`include "stack_cpu_defs.svh"

module stack_cpu_tb;

  // alu field codes of the stack-only instructions
  localparam logic [5:0] op_a   = 6'h00;  // pass top, DUP with push set
  localparam logic [5:0] op_and = 6'h10;
  localparam logic [5:0] op_or  = 6'h11;
  localparam logic [5:0] op_xor = 6'h12;
  localparam logic [5:0] op_shr = 6'h14;
  localparam logic [5:0] op_sar = 6'h15;
  localparam logic [5:0] op_shl = 6'h16;
  localparam logic [5:0] op_add = 6'h20;
  localparam logic [5:0] op_sub = 6'h21;
  localparam logic [5:0] op_eq  = 6'h28;
  localparam logic [5:0] op_neq = 6'h29;
  localparam logic [5:0] op_lt  = 6'h2a;
  localparam logic [5:0] op_bt  = 6'h2c;
  localparam logic [5:0] br_jmp = 6'b000100;  // upper six opcode bits
  localparam logic [5:0] br_jz  = 6'b000110;
  localparam logic [5:0] add_fp = 6'b000101;
  localparam logic [1:0] x_zero = 2'd0;
  localparam logic [1:0] x_fp   = 2'd1;
  localparam logic [1:0] x_dp   = 2'd2;

  // result addresses, word aligned
  localparam stack_cpu_pkg::addr_t alu_base      = 14'h0040;
  localparam stack_cpu_pkg::addr_t br_base       = 14'h0060;
  localparam stack_cpu_pkg::addr_t call_sub_addr = 14'h0070;
  localparam stack_cpu_pkg::addr_t call_ret_addr = 14'h0072;
  localparam stack_cpu_pkg::addr_t poison_addr   = 14'h007e;  // skipped code only
  localparam stack_cpu_pkg::addr_t mem_base      = 14'h0080;
  localparam stack_cpu_pkg::addr_t byte_base     = 14'h0090;
  localparam stack_cpu_pkg::addr_t done_addr     = 14'h00fe;
  localparam int num_tests = 6;

  logic                     clk;
  logic                     rst;
  stack_cpu_pkg::addr_t     pmem_addr;
  stack_cpu_pkg::insn_t     pmem_rdata = '0;
  stack_cpu_pkg::dmem_req_t dmem;
  stack_cpu_pkg::word_t     dmem_rdata = '0;

  stack_cpu_pkg::insn_t pmem_mem [1 << `STACK_CPU_ADDR_W];
  stack_cpu_pkg::word_t dmem_mem [1 << (`STACK_CPU_ADDR_W - 1)];  // addr bit 0 picks the lane

  stack_cpu_pkg::word_t exp_val  [stack_cpu_pkg::addr_t];  // outstanding result stores
  int                   exp_test [stack_cpu_pkg::addr_t];
  string test_name [num_tests] = '{"reset", "alu", "branch", "call", "memory", "byte"};
  int    errs    [num_tests];
  int    pending [num_tests];
  int    pc = 0;
  int    prog_cycles = 0;
  int    cycles = 0;
  int    cycle_limit;
  logic  done_seen = 1'b0;
  logic  sub_seen = 1'b0;

  stack_cpu u_dut (
    .clk        (clk),
    .rst        (rst),
    .pmem_addr  (pmem_addr),
    .pmem_rdata (pmem_rdata),
    .dmem       (dmem),
    .dmem_rdata (dmem_rdata)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // synchronous memories, one cycle read latency
  always @(posedge clk) begin
    pmem_rdata <= #1 pmem_mem[pmem_addr];
  end

  always @(posedge clk) begin
    if (dmem.wen) begin
      if (!dmem.byt) dmem_mem[dmem.addr[`STACK_CPU_ADDR_W-1:1]] <= dmem.wdata;
      else if (dmem.addr[0]) dmem_mem[dmem.addr[`STACK_CPU_ADDR_W-1:1]][15:8] <= dmem.wdata[15:8];
      else dmem_mem[dmem.addr[`STACK_CPU_ADDR_W-1:1]][7:0] <= dmem.wdata[7:0];
    end
    if (dmem.ren) dmem_rdata <= #1 dmem_mem[dmem.addr[`STACK_CPU_ADDR_W-1:1]];
  end

  always @(posedge clk) begin
    if (!rst) cycles <= cycles + 1;
  end

  // stores are stable mid cycle
  always @(negedge clk) begin
    if (!rst && dmem.wen) check_store(dmem.addr, dmem.wdata);
  end

  function automatic stack_cpu_pkg::word_t rand_word();
    return stack_cpu_pkg::word_t'($urandom);
  endfunction

  // second pushed operand is x, top is y
  function automatic stack_cpu_pkg::word_t alu_rule(input logic [5:0] code,
                                                    input stack_cpu_pkg::word_t x,
                                                    input stack_cpu_pkg::word_t y);
    case (code)
      op_add:  return x + y;
      op_sub:  return x - y;
      op_and:  return x & y;
      op_or:   return x | y;
      op_xor:  return x ^ y;
      op_shr:  return x >> y;
      op_sar:  return $signed(x) >>> y;
      op_shl:  return x << y;
      op_eq:   return (x == y) ? 16'd1 : 16'd0;
      op_neq:  return (x != y) ? 16'd1 : 16'd0;
      op_lt:   return ($signed(x) < $signed(y)) ? 16'd1 : 16'd0;
      op_bt:   return (x < y) ? 16'd1 : 16'd0;  // unsigned below
      default: return 'x;
    endcase
  endfunction

  task automatic emit(input stack_cpu_pkg::insn_t word, input int cyc);
    pmem_mem[pc] = word;
    pc++;
    prog_cycles += cyc;  // straight line upper bound
  endtask

  task automatic push_imm(input stack_cpu_pkg::word_t v);
    emit({2'b11, v}, 2);
  endtask

  task automatic push_rel(input logic [1:0] x, input stack_cpu_pkg::addr_t off);
    emit({4'b0101, x, off[11:0]}, 2);
  endtask

  task automatic st_word(input logic [1:0] x, input stack_cpu_pkg::addr_t off);
    emit({4'b0100, x, off[11:1], 1'b1}, 2);  // bit 0 set marks the store
  endtask

  task automatic ld_word(input logic [1:0] x, input stack_cpu_pkg::addr_t off);
    emit({4'b0100, x, off[11:1], 1'b0}, 3);
  endtask

  task automatic st_byte(input logic [1:0] x, input stack_cpu_pkg::addr_t off);
    emit({4'b0011, x, off[11:0]}, 2);
  endtask

  task automatic ld_byte(input logic [1:0] x, input stack_cpu_pkg::addr_t off);
    emit({4'b0010, x, off[11:0]}, 3);
  endtask

  task automatic stack_op(input logic [5:0] code, input logic push, input logic pop);
    emit({6'b011100, 4'b0000, push, pop, code}, 2);
  endtask

  task automatic jump_rel(input logic [5:0] opc, input logic [11:0] off);
    emit({opc, off}, 2);  // relative to the next instruction
  endtask

  task automatic expect_store(input int t, input stack_cpu_pkg::addr_t a,
                              input stack_cpu_pkg::word_t v);
    exp_val[a] = v;
    exp_test[a] = t;
    pending[t]++;
  endtask

  task automatic finish_test(input int t);
    if (errs[t] == 0) $display("test %s: passed", test_name[t]);
    else $display("test %s: failed with %0d errors", test_name[t], errs[t]);
  endtask

  task automatic check_store(input stack_cpu_pkg::addr_t a, input stack_cpu_pkg::word_t d);
    int t;
    assert (a != poison_addr) else begin
      $display("branch: store to poison address %h, skipped code was executed", a);
      errs[2]++;
    end
    if (a == done_addr) done_seen = 1'b1;
    if (exp_test.exists(a)) begin
      t = exp_test[a];
      assert (d == exp_val[a]) else begin
        $display("FAILED %s: addr %h expected %h actual %h", test_name[t], a, exp_val[a], d);
        errs[t]++;
      end
      if (a == call_ret_addr) begin
        assert (sub_seen) else begin
          $display("call: return marker stored before the subroutine marker");
          errs[3]++;
        end
      end
      if (a == call_sub_addr) sub_seen = 1'b1;
      exp_test.delete(a);  // a repeat store is not counted
      pending[t]--;
      if (pending[t] == 0) finish_test(t);
    end
  endtask

  task automatic reset_quiet(input string when);
    assert (!dmem.ren && !dmem.wen && pmem_addr == '0) else begin
      $display("reset %s: memory strobes not low or fetch address not 0", when);
      errs[0]++;
    end
  endtask

  task automatic build_program();
    logic [5:0] codes [12];
    stack_cpu_pkg::word_t x;
    stack_cpu_pkg::word_t y;
    stack_cpu_pkg::word_t sub_mark;
    int k;
    int call_pc;
    int sub_pc;
    codes = '{op_add, op_sub, op_and, op_or, op_xor, op_shr, op_sar, op_shl,
              op_eq, op_neq, op_lt, op_bt};
    for (k = 0; k < 12; k++) begin
      x = rand_word();
      y = rand_word();
      if (codes[k] inside {op_shr, op_sar, op_shl}) y = {12'd0, y[3:0]};
      push_imm(x);
      if (codes[k] == op_eq) begin
        y = x;
        stack_op(op_a, 1'b1, 1'b0);  // DUP gives equal operands
      end else begin
        push_imm(y);
      end
      stack_op(codes[k], 1'b0, 1'b1);  // binary op, pop and replace top
      st_word(x_zero, alu_base + 2 * k);
      expect_store(1, alu_base + 2 * k, alu_rule(codes[k], x, y));
    end
    // JZ taken on zero
    push_imm(16'h0000);
    jump_rel(br_jz, 12'd2);
    push_imm(16'hdead);
    st_word(x_zero, poison_addr);
    push_imm(16'h1111);
    st_word(x_zero, br_base);
    expect_store(2, br_base, 16'h1111);
    // JZ falls through on nonzero
    push_imm(rand_word() | 16'h0001);
    jump_rel(br_jz, 12'd2);
    push_imm(16'h2222);
    st_word(x_zero, br_base + 2);
    expect_store(2, br_base + 2, 16'h2222);
    jump_rel(br_jmp, 12'd2);
    push_imm(16'hdead);
    st_word(x_zero, poison_addr);
    push_imm(16'h3333);
    st_word(x_zero, br_base + 4);
    expect_store(2, br_base + 4, 16'h3333);
    // CALL, target filled in below
    call_pc = pc;
    emit('0, 2);
    x = rand_word();
    push_imm(x);
    st_word(x_zero, call_ret_addr);
    expect_store(3, call_ret_addr, x);
    sub_mark = rand_word();
    expect_store(3, call_sub_addr, sub_mark);
    // word store and load through fp and dp
    x = rand_word();
    y = rand_word();
    push_imm(x);
    st_word(x_fp, 14'h200);
    expect_store(4, stack_cpu_pkg::addr_t'(`STACK_CPU_FP_INIT + 16'h0200), x);
    push_imm(y);
    st_word(x_dp, 14'h020);
    expect_store(4, stack_cpu_pkg::addr_t'(`STACK_CPU_DP_INIT + 16'h0020), y);
    ld_word(x_fp, 14'h200);
    st_word(x_zero, mem_base);
    expect_store(4, mem_base, x);
    ld_word(x_dp, 14'h020);
    st_word(x_zero, mem_base + 2);
    expect_store(4, mem_base + 2, y);
    jump_rel(add_fp, 12'h010);  // fp += 16
    push_rel(x_fp, 14'h000);
    st_word(x_zero, mem_base + 4);
    expect_store(4, mem_base + 4, `STACK_CPU_FP_INIT + 16'h0010);
    // byte lanes, odd then even address of one word
    x = rand_word();
    y = rand_word();
    push_imm(x);
    st_byte(x_dp, 14'h041);
    push_imm(y);
    st_byte(x_dp, 14'h040);
    ld_word(x_dp, 14'h040);
    st_word(x_zero, byte_base);
    expect_store(5, byte_base, {x[7:0], y[7:0]});
    ld_byte(x_dp, 14'h041);
    st_word(x_zero, byte_base + 2);
    expect_store(5, byte_base + 2, {8'h00, x[7:0]});
    ld_byte(x_dp, 14'h040);
    st_word(x_zero, byte_base + 4);
    expect_store(5, byte_base + 4, {8'h00, y[7:0]});
    push_imm(16'h00ff);
    st_word(x_zero, done_addr);
    jump_rel(br_jmp, 12'hfff);  // spin here
    // subroutine
    sub_pc = pc;
    push_imm(sub_mark);
    st_word(x_zero, call_sub_addr);
    emit({6'b011100, 1'b1, 11'd0}, 2);  // RET
    pmem_mem[call_pc] = {4'b0000, 14'(sub_pc - call_pc - 1)};
  endtask

  initial begin
    int t;
    int passed;
    int failed;
    void'($urandom(32'he5ad923a));
    rst = 1'b1;
    passed = 0;
    failed = 0;
    for (t = 0; t < (1 << `STACK_CPU_ADDR_W); t++) begin
      pmem_mem[t] = {2'b11, 16'(t)};  // stray fetches push their own address
    end
    for (t = 0; t < (1 << (`STACK_CPU_ADDR_W - 1)); t++) begin
      dmem_mem[t] = 16'(t) * 16'h9e37 ^ 16'h5a5a;
    end
    build_program();
    cycle_limit = 4 * prog_cycles;
    repeat (9) begin
      @(negedge clk);
      reset_quiet("during reset");
    end
    @(posedge clk);  // tenth edge in reset
    #1 rst = 1'b0;
    @(negedge clk);
    reset_quiet("after reset");
    finish_test(0);
    while (!done_seen && cycles < cycle_limit) @(posedge clk);
    if (!done_seen) $display("timeout: program did not finish within %0d cycles", cycle_limit);
    for (t = 0; t < num_tests; t++) begin
      if (pending[t] != 0) begin
        $display("test %s: %0d expected stores never seen", test_name[t], pending[t]);
      end
      if (errs[t] == 0 && pending[t] == 0) passed++;
      else failed++;
    end
    $display("tests passed %0d, failed %0d, assertion failures %0d",
             passed, failed, u_dut.u_chk.fail_cnt);
    if (failed == 0 && done_seen && u_dut.u_chk.fail_cnt == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule
